// File: common/riscv_types_pkg.sv
// RV32I instruction encodings: opcodes, function codes and instruction formats
package riscv_types_pkg;

    ////////////////////////////////////////////////////////////
    // Opcodes handled by the execution core
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    // funct3 field of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    ////////////////////////////////////////////////////////////
    // Internal ALU operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0] rd;
        logic [6:0] opcode;
    } u_type_t;

    // One instruction word, seen as R, I or U format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } rv_inst_t;

endpackage

// File: common/core_types_pkg.sv
// Core packet types for the instruction stream, issue, unit results, retire and trace
package core_types_pkg;

    // Instruction as delivered by the outside world
    typedef struct packed {
        logic [31:0] pc;
        riscv_types_pkg::rv_inst_t instruction;
    } fetch_packet_t;

    ////////////////////////////////////////////////////////////
    // Decoded instruction with its operands, sent to an ALU
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic imm_sel;
        riscv_types_pkg::alu_op_t alu_op;
        logic [4:0] rd;
    } issue_packet_t;

    // Result leaving an ALU towards writeback
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0] rd;
        logic [31:0] data;
    } unit_result_t;

    ////////////////////////////////////////////////////////////
    // Observation ports
    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [4:0] rd;
        logic [31:0] data;
    } retire_packet_t;

    typedef struct packed {
        logic instruction_issued;
        logic operand_stall;
        logic unit_stall;
        logic illegal_instruction;
        // At most one retirement per cycle today
        logic [1:0] num_retiring;
    } trace_outputs_t;

endpackage

// File: src/alu_unit.sv
// ALU unit: one registered stage of RV32I integer operations, held until writeback accepts
`timescale 1ns/1ps

module alu_unit (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input core_types_pkg::issue_packet_t issue_packet,
    output logic issue_ready,
    output logic wb_valid,
    output core_types_pkg::unit_result_t wb_result,
    input logic wb_ready
);
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [4:0] shamt;
    logic [31:0] result;

    ////////////////////////////////////////////////////////////
    // Operation
    assign operand_a = issue_packet.rs1_data;
    assign operand_b = issue_packet.imm_sel ? issue_packet.imm : issue_packet.rs2_data;
    assign shamt = operand_b[4:0];

    always_comb begin
        case (issue_packet.alu_op)
            riscv_types_pkg::ALU_ADD:  result = operand_a + operand_b;
            riscv_types_pkg::ALU_SUB:  result = operand_a - operand_b;
            riscv_types_pkg::ALU_SLL:  result = operand_a << shamt;
            riscv_types_pkg::ALU_SLT:
                result = {31'd0, $signed(operand_a) < $signed(operand_b)};
            riscv_types_pkg::ALU_SLTU: result = {31'd0, operand_a < operand_b};
            riscv_types_pkg::ALU_XOR:  result = operand_a ^ operand_b;
            riscv_types_pkg::ALU_SRL:  result = operand_a >> shamt;
            riscv_types_pkg::ALU_SRA:  result = 32'($signed(operand_a) >>> shamt);
            riscv_types_pkg::ALU_OR:   result = operand_a | operand_b;
            riscv_types_pkg::ALU_AND:  result = operand_a & operand_b;
            default:                   result = operand_a + operand_b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Result register
    // Free when empty or when the held result leaves this cycle
    assign issue_ready = ~wb_valid | wb_ready;

    always_ff @(posedge clk) begin
        if (rst)
            wb_valid <= 1'b0;
        else if (issue_ready)
            wb_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            wb_result.pc <= issue_packet.pc;
            wb_result.rd <= issue_packet.rd;
            wb_result.data <= result;
        end
    end

endmodule

// File: issue/decode_and_issue.sv
// Decode and issue: decodes RV32I ops, tracks busy registers and dispatches to the ALUs
`timescale 1ns/1ps

module decode_and_issue #(
    parameter int NUM_ALUS = 2
) (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input core_types_pkg::fetch_packet_t in_packet,
    output logic in_ready,
    output logic [4:0] rs1_addr,
    output logic [4:0] rs2_addr,
    input logic [31:0] rs1_data,
    input logic [31:0] rs2_data,
    output logic [NUM_ALUS-1:0] issue_valid,
    output core_types_pkg::issue_packet_t issue_packet,
    input logic [NUM_ALUS-1:0] issue_ready,
    input logic clear_valid,
    input logic [4:0] clear_rd,
    output logic ev_issued,
    output logic ev_operand_stall,
    output logic ev_unit_stall,
    output logic ev_illegal
);
    localparam int PTR_W = (NUM_ALUS > 1) ? $clog2(NUM_ALUS) : 1;
    localparam logic [PTR_W-1:0] LAST_ALU = PTR_W'(NUM_ALUS - 1);

    logic dec_valid;
    core_types_pkg::fetch_packet_t dec_packet;
    riscv_types_pkg::rv_inst_t inst;
    logic legal;
    logic imm_sel;
    riscv_types_pkg::alu_op_t alu_op;
    logic [31:0] imm;
    logic [4:0] rd;
    logic [31:0] busy;
    logic [31:0] busy_now;
    logic operand_hazard;
    logic rd_hazard;
    logic dispatch_ok;
    logic issue_fire;
    logic drop;
    logic [PTR_W-1:0] rr_ptr;

    function automatic riscv_types_pkg::alu_op_t to_alu_op(input logic [2:0] funct3,
                                                           input logic alt);
        case (funct3)
            riscv_types_pkg::F3_ADD_SUB: return alt ? riscv_types_pkg::ALU_SUB : riscv_types_pkg::ALU_ADD;
            riscv_types_pkg::F3_SLL:     return riscv_types_pkg::ALU_SLL;
            riscv_types_pkg::F3_SLT:     return riscv_types_pkg::ALU_SLT;
            riscv_types_pkg::F3_SLTU:    return riscv_types_pkg::ALU_SLTU;
            riscv_types_pkg::F3_XOR:     return riscv_types_pkg::ALU_XOR;
            riscv_types_pkg::F3_SRL_SRA: return alt ? riscv_types_pkg::ALU_SRA : riscv_types_pkg::ALU_SRL;
            riscv_types_pkg::F3_OR:      return riscv_types_pkg::ALU_OR;
            default:                     return riscv_types_pkg::ALU_AND;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Decode register
    assign in_ready = ~dec_valid | issue_fire | drop;

    always_ff @(posedge clk) begin
        if (rst)
            dec_valid <= 1'b0;
        else if (in_ready)
            dec_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            dec_packet <= in_packet;
    end

    ////////////////////////////////////////////////////////////
    // Decode
    assign inst = dec_packet.instruction;
    assign rd = inst.r.rd;

    always_comb begin
        legal = 1'b1;
        imm_sel = 1'b0;
        imm = 32'($signed(inst.i.imm));
        rs1_addr = inst.r.rs1;
        rs2_addr = inst.r.rs2;
        alu_op = to_alu_op(inst.r.funct3, inst.r.funct7[5]);
        case (inst.r.opcode)
            riscv_types_pkg::OP: ;
            riscv_types_pkg::OP_IMM: begin
                imm_sel = 1'b1;
                rs2_addr = 5'd0;
                // Only shifts carry a function bit in the immediate
                alu_op = to_alu_op(inst.i.funct3,
                    inst.i.funct3 == riscv_types_pkg::F3_SRL_SRA && inst.r.funct7[5]);
            end
            riscv_types_pkg::LUI: begin
                imm_sel = 1'b1;
                imm = {inst.u.imm20, 12'd0};
                rs1_addr = 5'd0;
                rs2_addr = 5'd0;
                alu_op = riscv_types_pkg::ALU_ADD;
            end
            default: legal = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Scoreboard
    // A clear arriving this cycle already frees the register
    assign busy_now = busy & ~({31'd0, clear_valid} << clear_rd);
    assign operand_hazard = busy_now[rs1_addr] | busy_now[rs2_addr];
    assign rd_hazard = busy_now[rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (clear_valid)
                busy[clear_rd] <= 1'b0;
            if (issue_fire && rd != 5'd0)
                busy[rd] <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Dispatch
    assign dispatch_ok = dec_valid & legal & ~operand_hazard & ~rd_hazard;
    assign issue_fire = dispatch_ok & issue_ready[rr_ptr];
    assign drop = dec_valid & ~legal;

    always_comb begin
        issue_valid = '0;
        issue_valid[rr_ptr] = dispatch_ok;
    end

    always_ff @(posedge clk) begin
        if (rst)
            rr_ptr <= '0;
        else if (issue_fire)
            rr_ptr <= (rr_ptr == LAST_ALU) ? '0 : rr_ptr + 1'b1;
    end

    assign issue_packet.pc = dec_packet.pc;
    assign issue_packet.rs1_data = rs1_data;
    assign issue_packet.rs2_data = rs2_data;
    assign issue_packet.imm = imm;
    assign issue_packet.imm_sel = imm_sel;
    assign issue_packet.alu_op = alu_op;
    assign issue_packet.rd = rd;

    // Events for the trace port
    assign ev_issued = issue_fire;
    assign ev_operand_stall = dec_valid & legal & (operand_hazard | rd_hazard);
    assign ev_unit_stall = dispatch_ok & ~issue_ready[rr_ptr];
    assign ev_illegal = drop;

endmodule

// File: writeback/register_file_and_writeback.sv
// Register file and writeback: arbitrates ALU results, writes registers and reports retirement
`timescale 1ns/1ps

module register_file_and_writeback #(
    parameter int NUM_ALUS = 2
) (
    input logic clk,
    input logic rst,
    input logic [NUM_ALUS-1:0] wb_valid,
    input core_types_pkg::unit_result_t [NUM_ALUS-1:0] wb_result,
    output logic [NUM_ALUS-1:0] wb_ready,
    input logic [4:0] rs1_addr,
    input logic [4:0] rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic clear_valid,
    output logic [4:0] clear_rd,
    output core_types_pkg::retire_packet_t retire,
    output logic ev_retiring
);
    localparam int PTR_W = (NUM_ALUS > 1) ? $clog2(NUM_ALUS) : 1;
    localparam logic [PTR_W-1:0] LAST_ALU = PTR_W'(NUM_ALUS - 1);

    logic [31:0] regs [32];
    logic [PTR_W-1:0] wb_ptr;
    logic [PTR_W-1:0] grant_idx;
    logic grant_valid;
    core_types_pkg::unit_result_t granted;

    ////////////////////////////////////////////////////////////
    // Round-robin arbiter, search starts at wb_ptr
    always_comb begin
        int unsigned idx;
        grant_valid = 1'b0;
        grant_idx = wb_ptr;
        for (int k = 0; k < NUM_ALUS; k++) begin
            idx = (int'(wb_ptr) + k) % NUM_ALUS;
            if (!grant_valid && wb_valid[idx]) begin
                grant_valid = 1'b1;
                grant_idx = PTR_W'(idx);
            end
        end
    end

    always_comb begin
        wb_ready = '0;
        wb_ready[grant_idx] = grant_valid;
    end

    assign granted = wb_result[grant_idx];

    always_ff @(posedge clk) begin
        if (rst)
            wb_ptr <= '0;
        else if (grant_valid)
            wb_ptr <= (grant_idx == LAST_ALU) ? '0 : grant_idx + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Register file, x0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++)
                regs[r] <= '0;
        end else if (grant_valid && granted.rd != 5'd0) begin
            regs[granted.rd] <= granted.data;
        end
    end

    // Reads see the write of this cycle
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 :
                      (grant_valid && granted.rd == rs1_addr) ? granted.data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 :
                      (grant_valid && granted.rd == rs2_addr) ? granted.data : regs[rs2_addr];

    ////////////////////////////////////////////////////////////
    // Scoreboard clear and retire
    assign clear_valid = grant_valid;
    assign clear_rd = granted.rd;
    assign ev_retiring = grant_valid;

    always_ff @(posedge clk) begin
        if (rst)
            retire.valid <= 1'b0;
        else
            retire.valid <= grant_valid;
        retire.pc <= granted.pc;
        retire.rd <= granted.rd;
        retire.data <= granted.data;
    end

endmodule

// File: src/rv_exec_core.sv
// RV32I execution core top level: decode/issue, ALU array, writeback and trace outputs
`timescale 1ns/1ps

module rv_exec_core #(
    parameter int NUM_ALUS = 2
) (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input core_types_pkg::fetch_packet_t in_packet,
    output logic in_ready,
    output core_types_pkg::retire_packet_t retire,
    output core_types_pkg::trace_outputs_t tr
);
    // Operand read ports
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    // Issue and writeback streams
    logic [NUM_ALUS-1:0] issue_valid;
    logic [NUM_ALUS-1:0] issue_ready;
    core_types_pkg::issue_packet_t issue_packet;
    logic [NUM_ALUS-1:0] wb_valid;
    logic [NUM_ALUS-1:0] wb_ready;
    core_types_pkg::unit_result_t [NUM_ALUS-1:0] wb_result;

    logic clear_valid;
    logic [4:0] clear_rd;

    // Trace events
    logic ev_issued;
    logic ev_operand_stall;
    logic ev_unit_stall;
    logic ev_illegal;
    logic ev_retiring;

    ////////////////////////////////////////////////////////////
    // Decode/Issue
    decode_and_issue #(.NUM_ALUS(NUM_ALUS)) decode_and_issue_block (.*);

    ////////////////////////////////////////////////////////////
    // Execution units
    for (genvar i = 0; i < NUM_ALUS; i++) begin : g_alu
        alu_unit alu_unit_block (
            .clk, .rst,
            .issue_valid(issue_valid[i]),
            .issue_packet,
            .issue_ready(issue_ready[i]),
            .wb_valid(wb_valid[i]),
            .wb_result(wb_result[i]),
            .wb_ready(wb_ready[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // Register file and writeback
    register_file_and_writeback #(.NUM_ALUS(NUM_ALUS)) register_file_and_writeback_block (.*);

    ////////////////////////////////////////////////////////////
    // Trace outputs, one cycle behind the events
    always_ff @(posedge clk) begin
        if (rst) begin
            tr <= '0;
        end else begin
            tr.instruction_issued <= ev_issued;
            tr.operand_stall <= ev_operand_stall;
            tr.unit_stall <= ev_unit_stall;
            tr.illegal_instruction <= ev_illegal;
            tr.num_retiring <= {1'b0, ev_retiring};
        end
    end

endmodule

// File: testbench/rv_exec_core_tb.sv
// Testbench for the RV32I execution core: directed tests checked against a program-order model
`timescale 1ns/1ps

module rv_exec_core_tb;
    localparam int NUM_ALUS = 2;

    logic clk;
    logic rst;
    logic in_valid;
    core_types_pkg::fetch_packet_t in_packet;
    logic in_ready;
    core_types_pkg::retire_packet_t retire;
    core_types_pkg::trace_outputs_t tr;

    // Reference model and bookkeeping
    logic [31:0] ref_regs [32];
    core_types_pkg::retire_packet_t exp_q[$];
    logic [31:0] next_pc;
    int legal_sent;
    int illegal_sent;
    int issued_seen;
    int illegal_seen;
    int retired_seen;
    int operand_stall_seen;
    int unit_stall_seen;
    int cycle_count;

    rv_exec_core #(.NUM_ALUS(NUM_ALUS)) dut0 (
        .clk, .rst, .in_valid, .in_packet, .in_ready, .retire, .tr
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Run length grows with the number of instructions sent
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 40 * (legal_sent + illegal_sent) + 100)
            stop_with_failure("Timeout: the core stopped retiring instructions");
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_retire(input core_types_pkg::retire_packet_t got,
                                input core_types_pkg::retire_packet_t exp);
        if (got.rd !== exp.rd)
            stop_with_failure($sformatf("** Error at %0t ns: retire.rd = %0d, expected %0d",
                                        $time, got.rd, exp.rd));
        // Values written to x0 are discarded, so only rd is compared
        else if (exp.rd != 5'd0 && got.data !== exp.data)
            stop_with_failure($sformatf("** Error at %0t ns: retire.data = %h, expected %h",
                                        $time, got.data, exp.data));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            stop_with_failure($sformatf("** Error at %0t ns: %s count = %0d, expected %0d",
                                        $time, name, got, exp));
    endtask

    task automatic match_retire(input core_types_pkg::retire_packet_t got);
        int idx;
        idx = -1;
        for (int k = 0; k < exp_q.size(); k++) begin
            if (idx < 0 && exp_q[k].pc == got.pc)
                idx = k;
        end
        if (idx < 0) begin
            stop_with_failure($sformatf("Retire at pc %h matches no pending instruction",
                                        got.pc));
        end else begin
            check_retire(got, exp_q[idx]);
            exp_q.delete(idx);
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst) begin
            issued_seen += int'(tr.instruction_issued);
            illegal_seen += int'(tr.illegal_instruction);
            retired_seen += int'(tr.num_retiring);
            operand_stall_seen += int'(tr.operand_stall);
            unit_stall_seen += int'(tr.unit_stall);
            if (retire.valid)
                match_retire(retire);
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction encoding and the RV32I reference
    function automatic riscv_types_pkg::rv_inst_t r_inst(input logic [6:0] funct7,
            input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] funct3,
            input logic [4:0] rd);
        riscv_types_pkg::rv_inst_t inst;
        inst.r = '{funct7, rs2, rs1, funct3, rd, riscv_types_pkg::OP};
        return inst;
    endfunction

    function automatic riscv_types_pkg::rv_inst_t i_inst(input logic [11:0] imm,
            input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
        riscv_types_pkg::rv_inst_t inst;
        inst.i = '{imm, rs1, funct3, rd, riscv_types_pkg::OP_IMM};
        return inst;
    endfunction

    function automatic riscv_types_pkg::rv_inst_t u_inst(input logic [19:0] imm20,
            input logic [4:0] rd);
        riscv_types_pkg::rv_inst_t inst;
        inst.u = '{imm20, rd, riscv_types_pkg::LUI};
        return inst;
    endfunction

    function automatic logic [31:0] expected_value(input logic [31:0] word);
        logic [31:0] a;
        logic [31:0] b;
        logic alt;
        a = ref_regs[word[19:15]];
        b = (word[6:0] == riscv_types_pkg::OP) ? ref_regs[word[24:20]]
                                               : {{20{word[31]}}, word[31:20]};
        alt = word[30];
        if (word[6:0] == riscv_types_pkg::LUI)
            return {word[31:12], 12'd0};
        case (word[14:12])
            3'd0: return (word[6:0] == riscv_types_pkg::OP && alt) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    task automatic send_inst(input riscv_types_pkg::rv_inst_t inst);
        logic [31:0] word;
        core_types_pkg::retire_packet_t exp;
        word = inst;
        in_packet.pc = next_pc;
        in_packet.instruction = inst;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (word[6:0] == riscv_types_pkg::OP || word[6:0] == riscv_types_pkg::OP_IMM ||
            word[6:0] == riscv_types_pkg::LUI) begin
            exp = '{1'b1, next_pc, word[11:7], expected_value(word)};
            exp_q.push_back(exp);
            if (word[11:7] != 5'd0)
                ref_regs[word[11:7]] = exp.data;
            legal_sent++;
        end else begin
            illegal_sent++;
        end
        next_pc += 32'd4;
    endtask

    // LUI plus ADDI, with the upper part rounded for the signed low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        send_inst(u_inst(upper[19:0], rd));
        send_inst(i_inst(value[11:0], rd, 3'd0, rd));
    endtask

    task automatic drain_and_check();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        #1;
        check_count("tr.instruction_issued", issued_seen, legal_sent);
        check_count("tr.illegal_instruction", illegal_seen, illegal_sent);
        check_count("tr.num_retiring", retired_seen, legal_sent);
        // Writeback takes each result the cycle after issue and frees its rd at once
        check_count("tr.operand_stall", operand_stall_seen, 0);
        check_count("tr.unit_stall", unit_stall_seen, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    task automatic test_alu_ops();
        logic [31:0] pos_val;
        logic [31:0] neg_val;
        pos_val = $urandom & 32'h7fff_ffff;
        neg_val = $urandom | 32'h8000_0000;
        load_const(5'd1, pos_val);
        load_const(5'd2, $urandom);
        load_const(5'd3, neg_val);
        // Negative rs1 against positive rs2 splits slt from sltu
        for (int f = 0; f < 8; f++)
            send_inst(r_inst(7'h00, 5'd1, 5'd3, 3'(f), 5'(8 + f)));
        send_inst(r_inst(7'h20, 5'd1, 5'd3, 3'd0, 5'd16));
        send_inst(r_inst(7'h20, 5'd2, 5'd3, 3'd5, 5'd17));
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5)
                send_inst(i_inst({7'h00, 5'($urandom)}, 5'd3, 3'(f), 5'(20 + f)));
            else
                send_inst(i_inst(12'($urandom), 5'd2, 3'(f), 5'(20 + f)));
        end
        send_inst(i_inst({7'h20, 5'($urandom)}, 5'd3, 3'd5, 5'd29));
        drain_and_check();
    endtask

    task automatic test_dependencies();
        send_inst(i_inst(12'd7, 5'd0, 3'd0, 5'd5));
        send_inst(r_inst(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
        send_inst(r_inst(7'h20, 5'd5, 5'd6, 3'd0, 5'd7));
        send_inst(r_inst(7'h00, 5'd6, 5'd7, 3'd4, 5'd5));
        repeat (6) send_inst(i_inst(12'd3, 5'd8, 3'd0, 5'd8));
        send_inst(r_inst(7'h00, 5'd8, 5'd5, 3'd0, 5'd9));
        drain_and_check();
    endtask

    task automatic test_back_to_back();
        for (int n = 0; n < 12; n++)
            send_inst(i_inst(12'($urandom), 5'd0, 3'd0, 5'(10 + n)));
        drain_and_check();
    endtask

    task automatic test_x0_writes();
        send_inst(i_inst(12'h123, 5'd0, 3'd0, 5'd0));
        send_inst(u_inst(20'habcde, 5'd0));
        send_inst(r_inst(7'h00, 5'd1, 5'd2, 3'd0, 5'd0));
        send_inst(r_inst(7'h00, 5'd1, 5'd0, 3'd0, 5'd11));
        send_inst(r_inst(7'h00, 5'd0, 5'd2, 3'd0, 5'd12));
        drain_and_check();
    endtask

    task automatic test_illegal();
        send_inst(i_inst(12'h05a, 5'd1, 3'd0, 5'd13));
        send_inst(32'h0000_2083);
        send_inst(r_inst(7'h00, 5'd1, 5'd13, 3'd0, 5'd14));
        send_inst(32'h0020_8463);
        send_inst(32'h0000_0073);
        send_inst(r_inst(7'h20, 5'd13, 5'd14, 3'd0, 5'd15));
        drain_and_check();
    endtask

    initial begin
        void'($urandom(96));
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_packet = '0;
        next_pc = 32'h0000_1000;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = 32'd0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_alu_ops();
        test_dependencies();
        test_back_to_back();
        test_x0_writes();
        test_illegal();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: rv_exec_core.f
common/riscv_types_pkg.sv
common/core_types_pkg.sv
src/alu_unit.sv
issue/decode_and_issue.sv
writeback/register_file_and_writeback.sv
src/rv_exec_core.sv
testbench/rv_exec_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the execution core and its testbench with Verilator, run it and check the result

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module rv_exec_core_tb \
    -f rv_exec_core.f \
    -o rv_exec_core_sim
compile_status=$?
if [ "$compile_status" -ne 0 ]; then
    echo "Compilation failed with status $compile_status"
    exit 1
fi

sim_output=$(./obj_dir/rv_exec_core_sim 2>&1)
run_status=$?
echo "$sim_output"

if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "RESULT: PASS" <<< "$sim_output"; then
    exit 0
else
    echo "Pass message not found in the simulation output"
    exit 1
fi
